// File: filelist.f
rtl/cache_pkg.sv
rtl/cache_bit_array.sv
rtl/cache_ctrl.sv
rtl/cache_dpath.sv
rtl/blocking_cache.sv
verif/cache_mem_model.sv
verif/cache_tb.sv

// File: rtl/blocking_cache.sv
/*
 * Blocking direct-mapped write-back cache
 * Joins the controller and the datapath
 */
`timescale 1ns/1ps

module blocking_cache
  import cache_pkg::*;
(
  input  logic        clk,
  input  logic        reset,

  // Processor side
  input  cache_req_t  cache_req,
  input  logic        req_val,
  output logic        req_rdy,
  output cache_resp_t cache_resp,
  output logic        resp_val,
  input  logic        resp_rdy,

  // Memory side
  output mem_req_t    mem_req,
  output logic        mem_req_val,
  input  logic        mem_req_rdy,
  input  mem_resp_t   mem_resp,
  input  logic        mem_resp_val,
  output logic        mem_resp_rdy
);

  dpath_ctrl_t   ctrl;
  dpath_status_t status;
  logic          hit;

  cache_ctrl ctrl_unit (
    .clk          (clk),
    .reset        (reset),
    .req_val      (req_val),
    .req_rdy      (req_rdy),
    .resp_val     (resp_val),
    .resp_rdy     (resp_rdy),
    .mem_req_val  (mem_req_val),
    .mem_req_rdy  (mem_req_rdy),
    .mem_resp_val (mem_resp_val),
    .mem_resp_rdy (mem_resp_rdy),
    .status       (status),
    .ctrl         (ctrl),
    .hit          (hit)
  );

  cache_dpath dpath_unit (
    .clk        (clk),
    .cache_req  (cache_req),
    .cache_resp (cache_resp),
    .mem_req    (mem_req),
    .mem_resp   (mem_resp),
    .ctrl       (ctrl),
    .hit        (hit),
    .status     (status)
  );

endmodule

// File: rtl/cache_bit_array.sv
/*
 * Per-line state bit array
 * One resettable bit per cache line, combinational read, registered write
 */
`timescale 1ns/1ps

module cache_bit_array
  import cache_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  index_t read_index,
  output logic   read_bit,
  input  logic   write_en,
  input  index_t write_index,
  input  logic   write_bit
);

  logic [NUM_LINES-1:0] bits;

  always_ff @(posedge clk) begin
    if (reset) begin
      bits <= '0;
    end else if (write_en) begin
      bits[write_index] <= write_bit;
    end
  end

  assign read_bit = bits[read_index];

  // Index comes from the request register in the datapath
  write_index_known: assert property (
    @(posedge clk) disable iff (reset)
    write_en |-> !$isunknown(write_index)
  ) else $error("bit array write with unknown index");

endmodule

// File: rtl/cache_ctrl.sv
/*
 * Blocking cache controller
 * FSM for tag check, access, eviction and refill; owns valid and dirty bits
 */
`timescale 1ns/1ps

module cache_ctrl
  import cache_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  logic          req_val,
  output logic          req_rdy,
  output logic          resp_val,
  input  logic          resp_rdy,
  output logic          mem_req_val,
  input  logic          mem_req_rdy,
  input  logic          mem_resp_val,
  output logic          mem_resp_rdy,
  input  dpath_status_t status,
  output dpath_ctrl_t   ctrl,
  output logic          hit
);

  typedef enum logic [3:0] {
    IDLE,
    TAG_CHECK,
    INIT_ACCESS,
    READ_ACCESS,
    WRITE_ACCESS,
    EVICT_REQ,
    EVICT_WAIT,
    REFILL_REQ,
    REFILL_WAIT,
    REFILL_UPDATE,
    RESP
  } state_t;

  // Handshake outputs followed by the datapath controls
  typedef struct packed {
    logic        req_rdy;
    logic        resp_val;
    logic        mem_req_val;
    logic        mem_resp_rdy;
    dpath_ctrl_t dp;
  } cs_t;

  state_t state;
  state_t state_next;
  cs_t    cs;

  logic valid_bit;
  logic dirty_bit;
  logic lookup_hit;
  logic victim_dirty;
  logic hit_reg;
  logic valid_wen;
  logic dirty_wen;
  logic dirty_wbit;

  // ----------------------------------------
  // Valid and dirty state
  // ----------------------------------------
  cache_bit_array valid_bits (
    .clk         (clk),
    .reset       (reset),
    .read_index  (status.req_index),
    .read_bit    (valid_bit),
    .write_en    (valid_wen),
    .write_index (status.req_index),
    .write_bit   (1'b1)
  );

  cache_bit_array dirty_bits (
    .clk         (clk),
    .reset       (reset),
    .read_index  (status.req_index),
    .read_bit    (dirty_bit),
    .write_en    (dirty_wen),
    .write_index (status.req_index),
    .write_bit   (dirty_wbit)
  );

  assign lookup_hit   = valid_bit && status.tag_match;
  assign victim_dirty = valid_bit && dirty_bit;

  // Init and refill install the line and a write marks it dirty
  assign valid_wen  = (state == INIT_ACCESS) || (state == REFILL_UPDATE);
  assign dirty_wen  = valid_wen || (state == WRITE_ACCESS);
  assign dirty_wbit = (state == WRITE_ACCESS);

  // Hit decision is frozen at tag check, since a refill makes the tag match later
  always_ff @(posedge clk) begin
    if (reset) begin
      hit_reg <= 1'b0;
    end else if (state == TAG_CHECK) begin
      hit_reg <= lookup_hit || (status.req_type == INIT);
    end
  end

  assign hit = hit_reg;

  // ----------------------------------------
  // State register and next state
  // ----------------------------------------
  function automatic state_t access_state(input req_type_t t);
    case (t)
      INIT:    return INIT_ACCESS;
      WRITE:   return WRITE_ACCESS;
      default: return READ_ACCESS;
    endcase
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE:          if (req_val) state_next = TAG_CHECK;
      TAG_CHECK: begin
        if (status.req_type == INIT || lookup_hit) begin
          state_next = access_state(status.req_type);
        end else if (victim_dirty) begin
          state_next = EVICT_REQ;
        end else begin
          state_next = REFILL_REQ;
        end
      end
      INIT_ACCESS,
      READ_ACCESS,
      WRITE_ACCESS:  state_next = RESP;
      EVICT_REQ:     if (mem_req_rdy) state_next = EVICT_WAIT;
      EVICT_WAIT:    if (mem_resp_val) state_next = REFILL_REQ;
      REFILL_REQ:    if (mem_req_rdy) state_next = REFILL_WAIT;
      REFILL_WAIT:   if (mem_resp_val) state_next = REFILL_UPDATE;
      REFILL_UPDATE: state_next = access_state(status.req_type);
      RESP:          if (resp_rdy) state_next = IDLE;
      default:       state_next = IDLE;
    endcase
  end

  // ----------------------------------------
  // Control table
  // ----------------------------------------
  // Request and refill registers load every cycle of their state,
  // so the value held is the one present at the leaving edge
  always_comb begin
    case (state)
      //                req  rsp  mrq  mrs  req  tag  dat  full evc  rfl  rsp  mem
      //                rdy  val  val  rdy  en   wen  wen  line sel  en   en   type
      IDLE:          cs = {1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0,
                           1'b0, 1'b0, READ};
      TAG_CHECK:     cs = {1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
                           1'b0, 1'b0, READ};
      INIT_ACCESS:   cs = {1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0,
                           1'b0, 1'b1, READ};
      READ_ACCESS:   cs = {1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
                           1'b0, 1'b1, READ};
      WRITE_ACCESS:  cs = {1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0,
                           1'b0, 1'b1, READ};
      EVICT_REQ:     cs = {1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1,
                           1'b0, 1'b0, WRITE};
      EVICT_WAIT:    cs = {1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
                           1'b0, 1'b0, READ};
      REFILL_REQ:    cs = {1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
                           1'b0, 1'b0, READ};
      REFILL_WAIT:   cs = {1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
                           1'b1, 1'b0, READ};
      REFILL_UPDATE: cs = {1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0,
                           1'b0, 1'b0, READ};
      RESP:          cs = {1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
                           1'b0, 1'b0, READ};
      default:       cs = {1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
                           1'b0, 1'b0, READ};
    endcase
  end

  assign req_rdy      = cs.req_rdy;
  assign resp_val     = cs.resp_val;
  assign mem_req_val  = cs.mem_req_val;
  assign mem_resp_rdy = cs.mem_resp_rdy;
  assign ctrl         = cs.dp;

  // ----------------------------------------
  // Protocol checks
  // ----------------------------------------
  resp_held: assert property (
    @(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val
  ) else $error("resp_val dropped before resp_rdy");

  // Memory requests only follow a miss at tag check or a finished write-back
  mem_req_source: assert property (
    @(posedge clk) disable iff (reset)
    $rose(mem_req_val) |->
      !hit_reg && ($past(state) == TAG_CHECK || $past(state) == EVICT_WAIT)
  ) else $error("mem_req_val raised without a miss");

endmodule

// File: rtl/cache_dpath.sv
/*
 * Blocking cache datapath
 * Tag and data arrays, request and response registers, memory request forming
 */
`timescale 1ns/1ps

module cache_dpath
  import cache_pkg::*;
(
  input  logic          clk,
  input  cache_req_t    cache_req,
  output cache_resp_t   cache_resp,
  output mem_req_t      mem_req,
  input  mem_resp_t     mem_resp,
  input  dpath_ctrl_t   ctrl,
  input  logic          hit,
  output dpath_status_t status
);

  cache_req_t  req_reg;
  cache_resp_t resp_reg;
  line_t       refill_reg;

  tag_t  tag_array  [NUM_LINES];
  line_t data_array [NUM_LINES];

  index_t    req_index;
  tag_t      req_tag;
  word_sel_t req_word;
  tag_t      stored_tag;
  line_t     stored_line;
  line_t     merged_line;
  line_t     wr_line;
  word_t     read_word;
  logic [WORDS_PER_LINE-1:0] word_en;

  // ----------------------------------------
  // Request and refill capture
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (ctrl.req_en) begin
      req_reg <= cache_req;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.refill_en) begin
      refill_reg <= mem_resp.data;
    end
  end

  assign req_index = req_reg.addr[INDEX_LSB +: INDEX_W];
  assign req_tag   = req_reg.addr[TAG_LSB +: TAG_W];
  assign req_word  = req_reg.addr[WORD_LSB +: WORD_SEL_W];

  // ----------------------------------------
  // Arrays
  // ----------------------------------------
  assign stored_tag  = tag_array[req_index];
  assign stored_line = data_array[req_index];

  always_ff @(posedge clk) begin
    if (ctrl.tag_wen) begin
      tag_array[req_index] <= req_tag;
    end
  end

  // Pending write word lands on top of the refilled line
  always_comb begin
    merged_line = refill_reg;
    if (req_reg.req_type == WRITE) begin
      merged_line[req_word*WORD_W +: WORD_W] = req_reg.data;
    end
  end

  assign word_en = ctrl.full_line ? '1 : WORDS_PER_LINE'(1) << req_word;
  assign wr_line = ctrl.full_line ? merged_line : {WORDS_PER_LINE{req_reg.data}};

  always_ff @(posedge clk) begin
    if (ctrl.data_wen) begin
      for (int w = 0; w < WORDS_PER_LINE; w++) begin
        if (word_en[w]) begin
          data_array[req_index][w*WORD_W +: WORD_W] <= wr_line[w*WORD_W +: WORD_W];
        end
      end
    end
  end

  // ----------------------------------------
  // Response
  // ----------------------------------------
  assign read_word = stored_line[req_word*WORD_W +: WORD_W];

  // Only reads carry data back
  always_ff @(posedge clk) begin
    if (ctrl.resp_en) begin
      resp_reg.resp_type <= req_reg.req_type;
      resp_reg.opaque    <= req_reg.opaque;
      resp_reg.hit       <= hit;
      resp_reg.data      <= (req_reg.req_type == READ) ? read_word : '0;
    end
  end

  assign cache_resp = resp_reg;

  // ----------------------------------------
  // Memory request
  // ----------------------------------------
  // Eviction writes the victim back to its own line address
  assign mem_req.req_type = ctrl.mem_req_type;
  assign mem_req.addr     = ctrl.evict_sel ?
                            {stored_tag, req_index, {LINE_OFFSET_W{1'b0}}} :
                            {req_tag, req_index, {LINE_OFFSET_W{1'b0}}};
  assign mem_req.data     = stored_line;

  assign status.tag_match = (stored_tag == req_tag);
  assign status.req_type  = req_reg.req_type;
  assign status.req_index = req_index;

endmodule

// File: rtl/cache_pkg.sv
/*
 * Blocking cache package
 * Widths, address fields, request types and the structs shared by the cache
 */
package cache_pkg;

  // ----------------------------------------
  // Widths and address fields
  // ----------------------------------------
  localparam int ADDR_W         = 32;
  localparam int WORD_W         = 32;
  localparam int LINE_W         = 128;
  localparam int OPAQUE_W       = 8;
  localparam int INDEX_W        = 4;
  localparam int TAG_W          = 24;
  localparam int WORD_SEL_W     = 2;
  localparam int NUM_LINES      = 16;
  localparam int WORDS_PER_LINE = LINE_W / WORD_W;

  localparam int WORD_LSB       = 2;
  localparam int INDEX_LSB      = 4;
  localparam int TAG_LSB        = 8;
  // Byte offset bits below the index in a line address
  localparam int LINE_OFFSET_W  = INDEX_LSB;

  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [LINE_W-1:0]     line_t;
  typedef logic [OPAQUE_W-1:0]   opaque_t;
  typedef logic [INDEX_W-1:0]    index_t;
  typedef logic [TAG_W-1:0]      tag_t;
  typedef logic [WORD_SEL_W-1:0] word_sel_t;

  typedef enum logic [2:0] {
    READ  = 3'd0,
    WRITE = 3'd1,
    INIT  = 3'd2
  } req_type_t;

  // ----------------------------------------
  // Message structs
  // ----------------------------------------
  typedef struct packed {
    req_type_t req_type;
    opaque_t   opaque;
    addr_t     addr;
    word_t     data;
  } cache_req_t;

  typedef struct packed {
    req_type_t resp_type;
    opaque_t   opaque;
    logic      hit;
    word_t     data;
  } cache_resp_t;

  // Line-wide traffic with a line-aligned address
  typedef struct packed {
    req_type_t req_type;
    addr_t     addr;
    line_t     data;
  } mem_req_t;

  typedef struct packed {
    req_type_t resp_type;
    line_t     data;
  } mem_resp_t;

  // Controller to datapath
  typedef struct packed {
    logic      req_en;
    logic      tag_wen;
    logic      data_wen;
    logic      full_line;
    logic      evict_sel;
    logic      refill_en;
    logic      resp_en;
    req_type_t mem_req_type;
  } dpath_ctrl_t;

  typedef struct packed {
    logic      tag_match;
    req_type_t req_type;
    index_t    req_index;
  } dpath_status_t;

endpackage

// File: verif/cache_mem_model.sv
/*
 * Line-wide memory model for the cache testbench
 * Random request ready and a random 0 to 3 cycle response delay
 */
`timescale 1ns/1ps

module cache_mem_model
  import cache_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  mem_req_t  mem_req,
  input  logic      mem_req_val,
  output logic      mem_req_rdy,
  output mem_resp_t mem_resp,
  output logic      mem_resp_val,
  input  logic      mem_resp_rdy
);

  localparam word_t PATTERN_KEY = 32'h5A5A_C3C3;

  // Lines never written back read as the preset pattern
  line_t       lines [addr_t];
  mem_resp_t   pending;
  logic        busy;
  int unsigned delay;

  function automatic line_t read_line(input addr_t line_addr);
    line_t l;
    if (lines.exists(line_addr)) begin
      return lines[line_addr];
    end
    for (int w = 0; w < WORDS_PER_LINE; w++) begin
      l[w*WORD_W +: WORD_W] = word_t'((line_addr >> 2) + w) ^ PATTERN_KEY;
    end
    return l;
  endfunction

  initial begin
    busy         = 1'b0;
    delay        = 0;
    pending      = '0;
    mem_req_rdy  = 1'b0;
    mem_resp_val = 1'b0;
    mem_resp     = '0;
  end

  // Sample handshakes at the edge, drive outputs 1 ns later
  always @(posedge clk) begin
    if (reset) begin
      busy  = 1'b0;
      delay = 0;
    end else if (mem_resp_val && mem_resp_rdy) begin
      busy = 1'b0;
    end else if (mem_req_val && mem_req_rdy) begin
      busy              = 1'b1;
      delay             = $urandom_range(3);
      pending.resp_type = mem_req.req_type;
      pending.data      = (mem_req.req_type == WRITE) ? '0 : read_line(mem_req.addr);
      if (mem_req.req_type == WRITE) begin
        lines[mem_req.addr] = mem_req.data;
      end
    end else if (busy && delay != 0) begin
      delay = delay - 1;
    end
    #1;
    mem_req_rdy  = !reset && !busy && ($urandom_range(3) != 0);
    mem_resp_val = busy && (delay == 0);
    mem_resp     = pending;
  end

endmodule

// File: verif/cache_tb.sv
/*
 * Testbench for the blocking cache
 * Directed and random traffic against a reference model, checked by assertions
 */
`timescale 1ns/1ps

module cache_tb
  import cache_pkg::*;
();

  localparam word_t PATTERN_KEY = 32'h5A5A_C3C3;
  localparam int    WAIT_LIMIT  = 200;

  logic        clk;
  logic        reset;
  cache_req_t  cache_req;
  logic        req_val;
  logic        req_rdy;
  cache_resp_t cache_resp;
  logic        resp_val;
  logic        resp_rdy;
  mem_req_t    mem_req;
  logic        mem_req_val;
  logic        mem_req_rdy;
  mem_resp_t   mem_resp;
  logic        mem_resp_val;
  logic        mem_resp_rdy;

  // Reference model of memory and cache lines
  word_t ref_mem   [addr_t];
  word_t ref_line  [NUM_LINES][WORDS_PER_LINE];
  tag_t  ref_tag   [NUM_LINES];
  logic  ref_valid [NUM_LINES];
  logic  ref_dirty [NUM_LINES];

  // Expectations for the request in flight
  cache_resp_t exp_resp;
  logic        exp_hit;
  logic        exp_evict;
  addr_t       exp_victim_addr;
  line_t       exp_victim_line;
  addr_t       exp_refill_addr;
  string       test_name;
  opaque_t     next_opaque;
  logic        random_bp;

  blocking_cache uut (.*);

  cache_mem_model mem_model (.*);

  always #10 clk = ~clk;

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1);
  endtask

  function automatic word_t mem_word(input addr_t a);
    return ref_mem.exists(a) ? ref_mem[a] : (word_t'(a >> 2) ^ PATTERN_KEY);
  endfunction

  // Applies one request to the model and records what the DUT must do
  task automatic predict(input req_type_t t, input addr_t a, input word_t d);
    index_t    idx;
    tag_t      tg;
    word_sel_t ws;
    idx             = a[INDEX_LSB +: INDEX_W];
    tg              = a[TAG_LSB +: TAG_W];
    ws              = a[WORD_LSB +: WORD_SEL_W];
    exp_hit         = (ref_valid[idx] && ref_tag[idx] == tg) || (t == INIT);
    exp_evict       = !exp_hit && ref_valid[idx] && ref_dirty[idx];
    exp_victim_addr = {ref_tag[idx], idx, 4'h0};
    exp_refill_addr = {tg, idx, 4'h0};
    for (int w = 0; w < WORDS_PER_LINE; w++) begin
      exp_victim_line[w*WORD_W +: WORD_W] = ref_line[idx][w];
      if (exp_evict) begin
        ref_mem[exp_victim_addr + 4*w] = ref_line[idx][w];
      end
      if (!exp_hit) begin
        ref_line[idx][w] = mem_word(exp_refill_addr + 4*w);
      end
    end
    if (!exp_hit) begin
      ref_dirty[idx] = 1'b0;
    end
    ref_tag[idx]       = tg;
    ref_valid[idx]     = 1'b1;
    exp_resp.resp_type = t;
    exp_resp.opaque    = next_opaque;
    exp_resp.hit       = exp_hit;
    exp_resp.data      = (t == READ) ? ref_line[idx][ws] : '0;
    if (t != READ) begin
      ref_line[idx][ws] = d;
      ref_dirty[idx]    = (t == WRITE);
    end
  endtask

  // One request from issue to response handshake
  task automatic run_request(input req_type_t t, input addr_t a, input word_t d);
    int   n;
    logic done;
    predict(t, a, d);
    cache_req = '{req_type: t, opaque: next_opaque, addr: a, data: d};
    req_val   = 1'b1;
    n         = 0;
    while (!req_rdy) begin
      @(posedge clk);
      #1;
      n++;
      if (n > WAIT_LIMIT) stop_with_failure({"Timed out waiting for req_rdy in ", test_name});
    end
    @(posedge clk);
    #1;
    req_val = 1'b0;
    n       = 0;
    done    = 1'b0;
    while (!done) begin
      resp_rdy = random_bp ? ($urandom_range(3) != 0) : 1'b1;
      done     = resp_val && resp_rdy;
      @(posedge clk);
      #1;
      n++;
      if (!done && n > WAIT_LIMIT) begin
        stop_with_failure({"Timed out waiting for a response in ", test_name});
      end
    end
    resp_rdy    = 1'b0;
    next_opaque = next_opaque + 1;
  endtask

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  reset_state: assert property (@(posedge clk)
    $fell(reset) |-> req_rdy && !resp_val && !mem_req_val && !mem_resp_rdy
  ) else stop_with_failure("Handshake outputs wrong right after reset");

  resp_matches: assert property (@(posedge clk) disable iff (reset)
    resp_val && resp_rdy |-> cache_resp == exp_resp
  ) else stop_with_failure($sformatf("Mismatch in %s: expected %h, actual %h",
                                     test_name, exp_resp, $sampled(cache_resp)));

  hit_latency: assert property (@(posedge clk) disable iff (reset)
    req_val && req_rdy && exp_hit |-> ##2 !resp_val ##1 resp_val
  ) else stop_with_failure({"Hit response not three edges after acceptance in ", test_name});

  resp_stable: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> $stable(cache_resp)
  ) else stop_with_failure({"Response changed while stalled in ", test_name});

  evict_matches: assert property (@(posedge clk) disable iff (reset)
    mem_req_val && mem_req_rdy && mem_req.req_type == WRITE |->
      exp_evict && mem_req.addr == exp_victim_addr && mem_req.data == exp_victim_line
  ) else stop_with_failure($sformatf("Mismatch in %s: expected write-back %h, actual %h",
                                     test_name, {exp_victim_addr, exp_victim_line},
                                     $sampled({mem_req.addr, mem_req.data})));

  refill_matches: assert property (@(posedge clk) disable iff (reset)
    mem_req_val && mem_req_rdy && mem_req.req_type == READ |->
      !exp_hit && mem_req.addr == exp_refill_addr
  ) else stop_with_failure($sformatf("Mismatch in %s: expected refill %h, actual %h",
                                     test_name, exp_refill_addr, $sampled(mem_req.addr)));

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin
    index_t    r_idx;
    tag_t      r_tag;
    word_sel_t r_word;
    void'($urandom(94));
    clk         = 1'b0;
    reset       = 1'b1;
    req_val     = 1'b0;
    resp_rdy    = 1'b0;
    cache_req   = '0;
    random_bp   = 1'b0;
    next_opaque = '0;
    exp_resp    = '0;
    exp_hit     = 1'b0;
    exp_evict   = 1'b0;
    test_name   = "reset_read";
    for (int i = 0; i < NUM_LINES; i++) begin
      ref_valid[i] = 1'b0;
      ref_dirty[i] = 1'b0;
      ref_tag[i]   = '0;
    end
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;

    run_request(READ, 32'h0000_1230, '0);
    run_request(READ, 32'h0000_1238, '0);

    test_name = "init_read";
    for (int w = 0; w < WORDS_PER_LINE; w++) begin
      run_request(INIT, 32'h0000_2020 + 4*w, 32'hC0DE_0000 + w);
    end
    for (int w = 0; w < WORDS_PER_LINE; w++) begin
      run_request(READ, 32'h0000_2020 + 4*w, '0);
    end

    test_name = "write_read";
    run_request(READ, 32'h0000_3040, '0);
    run_request(WRITE, 32'h0000_3048, 32'hBEEF_0008);
    for (int w = 0; w < WORDS_PER_LINE; w++) begin
      run_request(READ, 32'h0000_3040 + 4*w, '0);
    end

    // Same index, different tag
    test_name = "dirty_evict";
    run_request(WRITE, 32'h0000_4058, 32'hD1E7_4058);
    run_request(READ, 32'h0000_5058, '0);
    run_request(READ, 32'h0000_4058, '0);

    test_name = "random";
    random_bp = 1'b1;
    repeat (200) begin
      r_idx  = index_t'($urandom_range(NUM_LINES - 1));
      r_tag  = tag_t'(24'h60 + $urandom_range(1));
      r_word = word_sel_t'($urandom_range(3));
      run_request($urandom_range(1) ? WRITE : READ, {r_tag, r_idx, r_word, 2'b00}, $urandom);
    end

    $display("Done: no errors");
    $finish;
  end

endmodule
